// File: dv/lsu_tb.sv
// ==============================
// LSU testbench
// directed and random requests checked against
// a byte level model of memory and peripherals
// ==============================
`timescale 1ns/10ps

module lsu_tb;

  localparam int MEM_WORDS   = 512;
  localparam int MEM_AW      = $clog2(4 * MEM_WORDS);  // byte address width
  localparam int CLK_PERIOD  = 10;
  localparam int SEED        = 73472;
  localparam int FILL_WORDS  = 16;                     // words loaded by random traffic
  localparam int N_DIRECTED  = 28;
  localparam int N_RANDOM    = 3000;
  localparam int N_TXN       = FILL_WORDS + 1 + N_DIRECTED + N_RANDOM;
  localparam int WATCHDOG_NS = (N_TXN * 20 + 10) * CLK_PERIOD;

  typedef struct packed {
    lsu_pkg::lsu_rsp_t rsp;
    logic [31:0]       cyc;    // cycle of acceptance
    logic              timed;  // accepted with ready held high
  } exp_t;

  logic              i_clk;
  logic              i_reset;
  logic              i_req_valid;
  lsu_pkg::lsu_req_t i_req;
  logic              o_req_ready;
  logic              o_rsp_valid;
  lsu_pkg::lsu_rsp_t o_rsp;
  logic              i_rsp_ready;
  logic [31:0]       i_io_sw;
  lsu_pkg::lsu_io_t  o_io;

  // ==============================
  // reference model state
  // ==============================
  logic [7:0]        mem_m [4*MEM_WORDS];
  bit                written [4*MEM_WORDS];
  logic [31:0]       io_m [5];             // indexed by io select
  exp_t              exp_q [$];
  logic [31:0]       cyc = '0;
  logic              ready_forced;
  logic              io_due = 1'b0;
  logic              held = 1'b0;
  lsu_pkg::lsu_rsp_t held_rsp;

  lsu_top #(
    .MEM_WORDS(MEM_WORDS)
  ) UUT (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_req_valid(i_req_valid),
    .i_req      (i_req),
    .o_req_ready(o_req_ready),
    .o_rsp_valid(o_rsp_valid),
    .o_rsp      (o_rsp),
    .i_rsp_ready(i_rsp_ready),
    .i_io_sw    (i_io_sw),
    .o_io       (o_io)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 32'd1;

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Timeout after %0d ns, the DUT stopped responding", WATCHDOG_NS));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    abort_run($sformatf("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch(name, 64'(got), 64'(exp));
    end
  endtask

  task automatic check_rsp(input string name, input lsu_pkg::lsu_rsp_t got,
                           input lsu_pkg::lsu_rsp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got rdata=0x%h err=%b expected rdata=0x%h err=%b",
                          $time, name, got.rdata, got.err, exp.rdata, exp.err));
    end
  endtask

  task automatic check_io(input lsu_pkg::lsu_io_t got, input lsu_pkg::lsu_io_t exp);
    if (got.ledr !== exp.ledr) begin
      report_mismatch("o_io.ledr", 64'(got.ledr), 64'(exp.ledr));
    end
    if (got.ledg !== exp.ledg) begin
      report_mismatch("o_io.ledg", 64'(got.ledg), 64'(exp.ledg));
    end
    if (got.lcd !== exp.lcd) begin
      report_mismatch("o_io.lcd", 64'(got.lcd), 64'(exp.lcd));
    end
    for (int n = 0; n < 8; n++) begin
      if (got.hex[n] !== exp.hex[n]) begin
        report_mismatch($sformatf("o_io.hex[%0d]", n), 64'(got.hex[n]), 64'(exp.hex[n]));
      end
    end
  endtask

  function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::lsu_op_e op,
                                                 input logic [31:0] addr,
                                                 input logic [31:0] wdata);
    lsu_pkg::lsu_req_t req;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic lsu_pkg::lsu_region_e region_of(input logic [31:0] addr);
    if (!addr[28] && (addr < 32'(4 * MEM_WORDS))) begin
      return lsu_pkg::REGION_DMEM;
    end
    if ((addr[31:16] == lsu_pkg::IO_OUT_BASE[31:16]) && (addr[14:12] <= 3'd4)) begin
      return lsu_pkg::REGION_OUT;
    end
    if (addr[31:16] == lsu_pkg::IO_IN_BASE[31:16]) begin
      return lsu_pkg::REGION_IN;
    end
    return lsu_pkg::REGION_NONE;
  endfunction

  function automatic lsu_pkg::lsu_io_t expected_io();
    lsu_pkg::lsu_io_t e;
    e.ledr = io_m[lsu_pkg::IO_LEDR];
    e.ledg = io_m[lsu_pkg::IO_LEDG];
    e.lcd  = io_m[lsu_pkg::IO_LCD];
    for (int n = 0; n < 4; n++) begin
      e.hex[n]     = io_m[lsu_pkg::IO_HEX03][8*n +: 7];
      e.hex[n + 4] = io_m[lsu_pkg::IO_HEX47][8*n +: 7];
    end
    return e;
  endfunction

  // ==============================
  // model of one accepted request
  // ==============================
  task automatic model_access(input lsu_pkg::lsu_req_t req, input logic [31:0] sw,
                              output lsu_pkg::lsu_rsp_t rsp);
    int                   size;
    int                   off;
    logic                 store;
    logic                 bad;
    logic [31:0]          word;
    logic [7:0]           b;
    logic [MEM_AW-1:0]    ba;
    lsu_pkg::lsu_region_e rgn;
    lsu_pkg::lsu_io_sel_e sel;
    case (req.op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = 2;
      default:                                size = 4;
    endcase
    off     = int'(req.addr[1:0]);
    store   = req.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    rgn     = region_of(req.addr);
    sel     = lsu_pkg::lsu_io_sel_e'(req.addr[14:12]);
    ba      = req.addr[MEM_AW-1:0];
    bad     = ((off % size) != 0) || (rgn == lsu_pkg::REGION_NONE) ||
              (store && (rgn == lsu_pkg::REGION_IN));
    rsp     = '0;
    rsp.err = bad;
    if (!bad && store) begin
      for (int i = 0; i < size; i++) begin
        b = req.wdata[8*i +: 8];                 // low bytes of store data
        if (rgn == lsu_pkg::REGION_DMEM) begin
          mem_m[ba + MEM_AW'(i)]   = b;
          written[ba + MEM_AW'(i)] = 1'b1;
        end else begin
          if ((sel == lsu_pkg::IO_HEX03) || (sel == lsu_pkg::IO_HEX47)) begin
            b[7] = 1'b0;                         // 7 segment digits
          end
          io_m[sel][8*(off + i) +: 8] = b;
        end
      end
    end else if (!bad) begin
      if (rgn == lsu_pkg::REGION_DMEM) begin
        for (int i = 0; i < size; i++) begin
          if (!written[ba + MEM_AW'(i)]) begin
            abort_run("Stimulus loads a data memory byte that was never written");
          end
        end
        ba[1:0] = 2'b00;
        for (int i = 0; i < 4; i++) begin
          word[8*i +: 8] = mem_m[ba + MEM_AW'(i)];
        end
      end else if (rgn == lsu_pkg::REGION_OUT) begin
        word = io_m[sel];
      end else begin
        word = sw;                               // switches at the accepting edge
      end
      word = word >> (8 * off);
      case (req.op)
        lsu_pkg::LB:  rsp.rdata = {{24{word[7]}}, word[7:0]};
        lsu_pkg::LH:  rsp.rdata = {{16{word[15]}}, word[15:0]};
        lsu_pkg::LBU: rsp.rdata = {24'h0, word[7:0]};
        lsu_pkg::LHU: rsp.rdata = {16'h0, word[15:0]};
        default:      rsp.rdata = word;
      endcase
    end
  endtask

  function automatic lsu_pkg::lsu_req_t random_req();
    int unsigned kind;
    logic [31:0] addr;
    kind = $urandom % 20;
    if (kind < 10) begin
      addr = 32'(($urandom % FILL_WORDS) * 4 + $urandom % 4);
    end else if (kind == 10) begin
      addr = 32'((MEM_WORDS - 1) * 4) + 32'($urandom % 4);  // last word
    end else if (kind < 15) begin
      addr = lsu_pkg::IO_OUT_BASE | (32'($urandom % 6) << 12) | 32'($urandom % 4);
    end else if (kind < 17) begin
      addr = lsu_pkg::IO_IN_BASE | ($urandom & 32'h0000_FFFF);
    end else if (kind == 17) begin
      addr = 32'(4 * MEM_WORDS) + ($urandom % 256);         // past the end of memory
    end else begin
      addr = $urandom | 32'h2000_0000;                      // unmapped
    end
    return make_req(lsu_pkg::lsu_op_e'(3'($urandom % 8)), addr, $urandom);
  endfunction

  // ==============================
  // drivers
  // ==============================
  task automatic send_req(input lsu_pkg::lsu_req_t req);
    i_req_valid = 1'b1;
    i_req       = req;
    @(negedge i_clk);
    while (!o_req_ready) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    i_req_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge i_clk);
    @(negedge i_clk);
    check_bit("o_rsp_valid", o_rsp_valid, 1'b0);  // nothing left in flight
    @(posedge i_clk);
    #1;
  endtask

  always @(posedge i_clk) begin
    int unsigned r;
    #1;
    r           = $urandom;
    i_io_sw     = $urandom;
    i_rsp_ready = ready_forced || ((r % 3) != 0);  // stall about one cycle in three
  end

  // monitor samples at the falling edge when inputs and outputs are settled
  always @(negedge i_clk) begin
    exp_t e;
    if (i_reset) begin
      if (io_due) begin
        check_io(o_io, expected_io());
      end
      if (held) begin
        check_bit("o_rsp_valid", o_rsp_valid, 1'b1);
        check_rsp("o_rsp while stalled", o_rsp, held_rsp);
      end
      if (o_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("DUT returned a response with no request outstanding");
        end
        e = exp_q.pop_front();
        check_rsp("o_rsp", o_rsp, e.rsp);
        if (e.timed && (cyc != e.cyc + 32'd2)) begin
          report_mismatch("response latency", 64'(cyc - e.cyc), 64'd2);
        end
      end
      held     = o_rsp_valid && !i_rsp_ready;
      held_rsp = o_rsp;
      io_due   = i_req_valid && o_req_ready;
      if (io_due) begin
        model_access(i_req, i_io_sw, e.rsp);
        e.cyc   = cyc;
        e.timed = ready_forced;
        exp_q.push_back(e);
      end
    end
  end

  // ==============================
  // test sequence
  // ==============================
  initial begin
    lsu_pkg::lsu_req_t dir_q [$];
    void'($urandom(SEED));
    i_reset      = 1'b0;
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_rsp_ready  = 1'b1;
    i_io_sw      = '0;
    ready_forced = 1'b1;
    for (int i = 0; i < 5; i++) begin
      io_m[i] = '0;
    end
    repeat (4) @(posedge i_clk);
    #1;
    i_reset = 1'b1;
    @(negedge i_clk);
    check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
    check_bit("o_req_ready", o_req_ready, 1'b1);
    check_io(o_io, '0);
    @(posedge i_clk);
    #1;

    for (int w = 0; w < FILL_WORDS; w++) begin
      send_req(make_req(lsu_pkg::SW, 32'(4 * w), $urandom));
    end
    send_req(make_req(lsu_pkg::SW, 32'(4 * (MEM_WORDS - 1)), $urandom));

    dir_q.push_back(make_req(lsu_pkg::SW,  32'h0000_0000, 32'h8000_7F80));
    dir_q.push_back(make_req(lsu_pkg::SB,  32'h0000_0001, 32'hFFFF_FFA5));
    dir_q.push_back(make_req(lsu_pkg::SH,  32'h0000_0002, 32'h5555_8123));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h0000_0000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LB,  32'h0000_0001, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LBU, 32'h0000_0001, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LH,  32'h0000_0002, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LHU, 32'h0000_0002, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LB,  32'h0000_0000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h0000_0002, 32'h0));         // misaligned
    dir_q.push_back(make_req(lsu_pkg::SH,  32'h0000_0003, 32'hFFFF_FFFF));
    dir_q.push_back(make_req(lsu_pkg::SW,  32'(4 * MEM_WORDS), 32'hDEAD_BEEF));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h2000_0000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::SW,  32'h1000_5000, 32'hFFFF_FFFF));  // no register 5
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h0000_0000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::SB,  32'h1000_0001, 32'h0000_00FF));
    dir_q.push_back(make_req(lsu_pkg::SH,  32'h1000_1002, 32'h0000_BEEF));
    dir_q.push_back(make_req(lsu_pkg::SB,  32'h1000_2003, 32'h0000_00FF));
    dir_q.push_back(make_req(lsu_pkg::SH,  32'h1000_3000, 32'h0000_FFFF));
    dir_q.push_back(make_req(lsu_pkg::SW,  32'h1000_4000, 32'h1234_5678));
    dir_q.push_back(make_req(lsu_pkg::SB,  32'h1000_4002, 32'h0000_00AB));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h1000_4000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LBU, 32'h1000_2003, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h1000_3000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h1001_0000, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::LH,  32'h1001_0002, 32'h0));
    dir_q.push_back(make_req(lsu_pkg::SW,  32'h1001_0000, 32'h0000_0001)); // switches read only
    dir_q.push_back(make_req(lsu_pkg::LW,  32'h1000_1000, 32'h0));
    foreach (dir_q[i]) begin
      send_req(dir_q[i]);
    end
    wait_drained();

    ready_forced = 1'b0;                          // random back-pressure from here
    for (int t = 0; t < N_RANDOM; t++) begin
      idle_cycles((($urandom % 4) == 0) ? 1 : 0);
      send_req(random_req());
    end
    wait_drained();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: project.f
rtl/lsu_pkg.sv
rtl/lsu_mem_bank.sv
rtl/lsu_store_align.sv
rtl/lsu_io_regs.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

// File: rtl/lsu_io_regs.sv
// ==============================
// LSU peripheral registers
// byte strobed LEDR, LEDG, HEX and LCD,
// switch sampling, registered read-back
// ==============================
`timescale 1ns/10ps

module lsu_io_regs (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_advance,
  input  lsu_pkg::lsu_lane_cmd_t i_cmd,
  input  lsu_pkg::lsu_region_e   i_region,
  input  logic [31:0]            i_io_sw,
  output logic [31:0]            o_rdata,
  output lsu_pkg::lsu_io_t       o_io
);

  logic [31:0]     ledr;
  logic [31:0]     ledg;
  logic [31:0]     lcd;
  logic [3:0][6:0] hex03;   // 7 segments per byte
  logic [3:0][6:0] hex47;
  logic            wr_en;
  logic [31:0]     sel_word;

  assign wr_en = i_advance && (i_region == lsu_pkg::REGION_OUT);

  // ==============================
  // output registers
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      ledr  <= '0;
      ledg  <= '0;
      lcd   <= '0;
      hex03 <= '0;
      hex47 <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (i_cmd.strb[b]) begin
          case (i_cmd.io_sel)
            lsu_pkg::IO_LEDR:  ledr[8*b +: 8] <= i_cmd.wdata[8*b +: 8];
            lsu_pkg::IO_LEDG:  ledg[8*b +: 8] <= i_cmd.wdata[8*b +: 8];
            lsu_pkg::IO_HEX03: hex03[b]       <= i_cmd.wdata[8*b +: 7];  // bit 7 dropped
            lsu_pkg::IO_HEX47: hex47[b]       <= i_cmd.wdata[8*b +: 7];
            lsu_pkg::IO_LCD:   lcd[8*b +: 8]  <= i_cmd.wdata[8*b +: 8];
            default: ;
          endcase
        end
      end
    end
  end

  // ==============================
  // read-back
  // ==============================
  always_comb begin
    case (i_cmd.io_sel)
      lsu_pkg::IO_LEDR:  sel_word = ledr;
      lsu_pkg::IO_LEDG:  sel_word = ledg;
      lsu_pkg::IO_HEX03: sel_word = {1'b0, hex03[3], 1'b0, hex03[2],
                                     1'b0, hex03[1], 1'b0, hex03[0]};
      lsu_pkg::IO_HEX47: sel_word = {1'b0, hex47[3], 1'b0, hex47[2],
                                     1'b0, hex47[1], 1'b0, hex47[0]};
      lsu_pkg::IO_LCD:   sel_word = lcd;
      default:           sel_word = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_advance) begin
      if (!i_cmd.rd) begin
        o_rdata <= '0;                           // stores and errors read nothing
      end else if (i_region == lsu_pkg::REGION_IN) begin
        o_rdata <= i_io_sw;                      // sampled at accept edge
      end else begin
        o_rdata <= sel_word;
      end
    end
  end

  always_comb begin
    o_io.ledr = ledr;
    o_io.ledg = ledg;
    o_io.lcd  = lcd;
    o_io.hex  = {hex47, hex03};   // digits 7..4 then 3..0
  end

endmodule

// File: rtl/lsu_load_align.sv
// ==============================
// LSU load aligner
// picks the source word, extracts and
// extends the loaded value, holds the
// response register and the stall
// ==============================
`timescale 1ns/10ps

module lsu_load_align (
  input  logic                i_clk,
  input  logic                i_reset,
  input  lsu_pkg::lsu_stage_t i_stage,
  input  logic [31:0]         i_mem_rdata,
  input  logic [31:0]         i_io_rdata,
  input  logic                i_rsp_ready,
  output logic                o_rsp_valid,
  output lsu_pkg::lsu_rsp_t   o_rsp,
  output logic                o_advance
);

  logic [31:0] src_word;
  logic [31:0] shifted;
  logic [31:0] ld_data;

  // pipe moves unless a response is waiting
  assign o_advance = !o_rsp_valid || i_rsp_ready;

  assign src_word = (i_stage.region == lsu_pkg::REGION_DMEM) ? i_mem_rdata : i_io_rdata;
  assign shifted  = src_word >> {i_stage.offset, 3'b000};

  // ==============================
  // extraction and extension
  // ==============================
  always_comb begin
    case (i_stage.op)
      lsu_pkg::LB:  ld_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::LH:  ld_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::LW:  ld_data = shifted;
      lsu_pkg::LBU: ld_data = {24'b0, shifted[7:0]};
      lsu_pkg::LHU: ld_data = {16'b0, shifted[15:0]};
      default:      ld_data = '0;   // stores return zero
    endcase
    if (i_stage.err) begin
      ld_data = '0;
    end
  end

  // ==============================
  // response register
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      o_rsp_valid <= 1'b0;
    end else if (o_advance) begin
      o_rsp_valid <= i_stage.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_advance) begin
      o_rsp.rdata <= ld_data;
      o_rsp.err   <= i_stage.err;
    end
  end

  // a held response keeps its value until taken
  a_rsp_hold : assert property (@(posedge i_clk) disable iff (!i_reset)
    (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)));

endmodule

// File: rtl/lsu_mem_bank.sv
// ==============================
// LSU data memory byte lane
// synchronous read-first RAM,
// read data held while disabled
// ==============================
`timescale 1ns/10ps

module lsu_mem_bank #(
  parameter int MEM_WORDS = 512
) (
  input  logic        i_clk,
  input  logic        i_en,
  input  logic        i_we,
  input  logic [31:0] i_index,
  input  logic [7:0]  i_wdata,
  output logic [7:0]  o_rdata
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [7:0]       mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = i_index[IDX_W-1:0];  // range checked upstream

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[idx] <= i_wdata;
      end
      o_rdata <= mem[idx];          // read-first returns the old contents
    end
  end

  // the aligner's range check keeps every write inside the array
  a_write_range : assert property (@(posedge i_clk)
    (i_en && i_we) |-> (i_index < 32'(MEM_WORDS)));

endmodule

// File: rtl/lsu_pkg.sv
// ==============================
// LSU shared definitions
// address map, opcodes, regions and the
// records passed between pipeline blocks
// ==============================
package lsu_pkg;

  // ==============================
  // address map
  // ==============================
  parameter logic [31:0] DMEM_BASE   = 32'h0000_0000;
  parameter logic [31:0] IO_OUT_BASE = 32'h1000_0000;  // bits 14:12 pick the register
  parameter logic [31:0] IO_IN_BASE  = 32'h1001_0000;  // switches

  // ==============================
  // enums
  // ==============================
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  typedef enum logic [1:0] {
    REGION_DMEM = 2'd0,
    REGION_OUT  = 2'd1,
    REGION_IN   = 2'd2,
    REGION_NONE = 2'd3
  } lsu_region_e;

  // values follow address bits 14:12
  typedef enum logic [2:0] {
    IO_LEDR  = 3'd0,
    IO_LEDG  = 3'd1,
    IO_HEX03 = 3'd2,
    IO_HEX47 = 3'd3,
    IO_LCD   = 3'd4
  } lsu_io_sel_e;

  // ==============================
  // structs
  // ==============================
  typedef struct packed {
    lsu_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } lsu_rsp_t;

  typedef struct packed {
    logic [3:0]  strb;    // write strobes stay zero unless a legal store
    logic [31:0] index;   // word index that users trim to depth
    logic [31:0] wdata;   // store data replicated into lanes
    logic        rd;      // legal load accepted
    lsu_region_e region;
    lsu_io_sel_e io_sel;
  } lsu_lane_cmd_t;

  typedef struct packed {
    logic        valid;
    lsu_op_e     op;
    logic [1:0]  offset;  // byte offset in word
    lsu_region_e region;
    lsu_io_sel_e io_sel;
    logic        err;
  } lsu_stage_t;

  typedef struct packed {
    logic [31:0]      ledr;
    logic [31:0]      ledg;
    logic [31:0]      lcd;
    logic [7:0][6:0]  hex;   // digit n in hex[n]
  } lsu_io_t;

endpackage

// File: rtl/lsu_store_align.sv
// ==============================
// LSU store aligner
// accepts requests, decodes region and size,
// builds lane strobes and store data,
// holds the stage register
// ==============================
`timescale 1ns/10ps

module lsu_store_align #(
  parameter int MEM_WORDS = 512
) (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_req_valid,
  input  lsu_pkg::lsu_req_t      i_req,
  output logic                   o_req_ready,
  input  logic                   i_advance,
  output lsu_pkg::lsu_lane_cmd_t o_cmd,
  output lsu_pkg::lsu_stage_t    o_stage
);

  localparam logic [31:0] DMEM_BYTES = 32'(4 * MEM_WORDS);

  logic                 accept;
  logic                 is_store;
  logic                 size_half;
  logic                 size_word;
  logic                 misalign;
  logic                 err;
  logic [31:0]          dmem_off;
  logic [3:0]           base_strb;
  logic [3:0]           strb;
  logic [31:0]          lane_data;
  lsu_pkg::lsu_region_e region;
  lsu_pkg::lsu_io_sel_e io_sel;

  assign o_req_ready = i_advance;              // ready whenever the pipe moves
  assign accept      = i_req_valid && o_req_ready;
  assign dmem_off    = i_req.addr - lsu_pkg::DMEM_BASE;
  assign io_sel      = lsu_pkg::lsu_io_sel_e'(i_req.addr[14:12]);

  // ==============================
  // opcode and address decode
  // ==============================
  always_comb begin
    is_store  = 1'b0;
    size_half = 1'b0;
    size_word = 1'b0;
    case (i_req.op)
      lsu_pkg::LH, lsu_pkg::LHU: size_half = 1'b1;
      lsu_pkg::LW:               size_word = 1'b1;
      lsu_pkg::SB:               is_store  = 1'b1;
      lsu_pkg::SH: begin
        is_store  = 1'b1;
        size_half = 1'b1;
      end
      lsu_pkg::SW: begin
        is_store  = 1'b1;
        size_word = 1'b1;
      end
      default: ;                               // LB, LBU are byte loads
    endcase
  end

  always_comb begin
    if (!i_req.addr[28] && (dmem_off < DMEM_BYTES)) begin
      region = lsu_pkg::REGION_DMEM;
    end else if ((i_req.addr[31:16] == lsu_pkg::IO_OUT_BASE[31:16]) &&
                 (i_req.addr[14:12] <= 3'd4)) begin
      region = lsu_pkg::REGION_OUT;
    end else if (i_req.addr[31:16] == lsu_pkg::IO_IN_BASE[31:16]) begin
      region = lsu_pkg::REGION_IN;
    end else begin
      region = lsu_pkg::REGION_NONE;
    end
  end

  assign misalign = (size_half && i_req.addr[0]) ||
                    (size_word && (i_req.addr[1:0] != 2'b00));
  assign err      = misalign || (region == lsu_pkg::REGION_NONE) ||
                    (is_store && (region == lsu_pkg::REGION_IN));  // switches are read only

  // ==============================
  // strobes and lane data
  // ==============================
  always_comb begin
    if (size_word) begin
      base_strb = 4'b1111;
      lane_data = i_req.wdata;
    end else if (size_half) begin
      base_strb = 4'b0011;
      lane_data = {2{i_req.wdata[15:0]}};
    end else begin
      base_strb = 4'b0001;
      lane_data = {4{i_req.wdata[7:0]}};
    end
  end

  assign strb = (is_store && !err) ? 4'(base_strb << i_req.addr[1:0]) : 4'b0000;

  always_comb begin
    o_cmd.strb   = accept ? strb : 4'b0000;
    o_cmd.index  = {2'b00, dmem_off[31:2]};
    o_cmd.wdata  = lane_data;
    o_cmd.rd     = accept && !is_store && !err;
    o_cmd.region = region;
    o_cmd.io_sel = io_sel;
  end

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      o_stage <= '0;
    end else if (i_advance) begin
      o_stage.valid  <= accept;
      o_stage.op     <= i_req.op;
      o_stage.offset <= i_req.addr[1:0];
      o_stage.region <= region;
      o_stage.io_sel <= io_sel;
      o_stage.err    <= err;
    end
  end

  // a clean store drives a legal lane pattern
  a_store_strb : assert property (@(posedge i_clk) disable iff (!i_reset)
    (accept && is_store && !err) |->
      (o_cmd.strb inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111}));

endmodule

// File: rtl/lsu_top.sv
// ==============================
// LSU top level
// store aligner, four byte-lane banks,
// peripheral registers and load aligner
// ==============================
`timescale 1ns/10ps

module lsu_top #(
  parameter int MEM_WORDS = 512
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_req_valid,
  input  lsu_pkg::lsu_req_t i_req,
  output logic              o_req_ready,
  output logic              o_rsp_valid,
  output lsu_pkg::lsu_rsp_t o_rsp,
  input  logic              i_rsp_ready,
  input  logic [31:0]       i_io_sw,
  output lsu_pkg::lsu_io_t  o_io
);

  lsu_pkg::lsu_lane_cmd_t cmd;
  lsu_pkg::lsu_stage_t    stage;
  logic [31:0]            mem_rdata;   // four bank bytes
  logic [31:0]            io_rdata;
  logic                   advance;     // pipeline enable

  lsu_store_align #(
    .MEM_WORDS(MEM_WORDS)
  ) u_store_align (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_req_valid(i_req_valid),
    .i_req      (i_req),
    .o_req_ready(o_req_ready),
    .i_advance  (advance),
    .o_cmd      (cmd),
    .o_stage    (stage)
  );

  // ==============================
  // data memory, one bank per byte lane
  // ==============================
  for (genvar k = 0; k < 4; k++) begin : g_bank
    lsu_mem_bank #(
      .MEM_WORDS(MEM_WORDS)
    ) u_bank (
      .i_clk  (i_clk),
      .i_en   (advance),
      .i_we   (cmd.strb[k] && (cmd.region == lsu_pkg::REGION_DMEM)),
      .i_index(cmd.index),
      .i_wdata(cmd.wdata[8*k +: 8]),
      .o_rdata(mem_rdata[8*k +: 8])
    );
  end

  lsu_io_regs u_io_regs (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_advance(advance),
    .i_cmd    (cmd),
    .i_region (cmd.region),
    .i_io_sw  (i_io_sw),
    .o_rdata  (io_rdata),
    .o_io     (o_io)
  );

  lsu_load_align u_load_align (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_stage    (stage),
    .i_mem_rdata(mem_rdata),
    .i_io_rdata (io_rdata),
    .i_rsp_ready(i_rsp_ready),
    .o_rsp_valid(o_rsp_valid),
    .o_rsp      (o_rsp),
    .o_advance  (advance)
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module lsu_tb \
  -f project.f -o lsu_sim > sim.log 2>&1 &&
  ./obj_dir/lsu_sim >> sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
